//--- Makefile
SIM      = verilator
FLAGS    = --timing --assert
TOP      = decodeExecuteTb
FILELIST = files.f
PASS     = >>> PASS

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The recipe fails unless the pass line shows up in the simulation output.
sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '$(PASS)' > /dev/null

clean:
	rm -rf obj_dir

//--- files.f
hdl/isaPkg.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/idExLatch.sv
hdl/executeStage.sv
hdl/decodeExecute.sv
tb/decodeExecute_sva.sv
tb/decodeExecuteTb.sv

//--- hdl/decodeExecute.sv
`timescale 1ns/1ns

module decodeExecute import isaPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  word    instr,
  input  word    pc,
  input  logic   en,
  input  logic   stall,
  output word    result,
  output regAddr resultReg,
  output logic   resultWrite,
  output word    memAddr,
  output word    memData,
  output logic   memWrite,
  output logic   memEn,
  output logic   dump,
  output logic   branchTaken,
  output word    branchTarget
);

  regAddr rsAddr, rtAddr, idRegDst;
  word    idImm, rsData, rtData;
  aluOp   idOp;
  logic   idAluSrcImm, idRegWrite, idMemWrite, idMemEn, idDump, idBranching, idJumping;

  // Latched fields for the instruction in execute.
  word    exPc, exA, exB, exImm;
  regAddr exRegDst;
  aluOp   exOp;
  logic   exAluSrcImm, exRegWrite, exMemWrite, exMemEn, exDump, exBranching, exJumping;

  logic   rfWrite;
  regAddr rfAddr;
  word    rfData;

  instrDecoder instrDecoder_i (
    .instr(instr), .rsAddr(rsAddr), .rtAddr(rtAddr), .imm(idImm), .regDstAddr(idRegDst),
    .op(idOp), .aluSrcImm(idAluSrcImm), .regWrite(idRegWrite), .memWrite(idMemWrite),
    .memEn(idMemEn), .dump(idDump), .branching(idBranching), .jumping(idJumping)
  );

  registerFile registerFile_i (
    .clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr), .writeAddr(rfAddr),
    .writeData(rfData), .write(rfWrite), .rsData(rsData), .rtData(rtData)
  );

  idExLatch idExLatch_i (
    .clk(clk), .rst(rst), .en(en), .stall(stall), .pcIn(pc), .aIn(rsData), .bIn(rtData),
    .immIn(idImm), .instrIn(instr), .regDstIn(idRegDst), .opIn(idOp),
    .aluSrcImmIn(idAluSrcImm), .regWriteIn(idRegWrite), .memWriteIn(idMemWrite),
    .memEnIn(idMemEn), .dumpIn(idDump), .branchingIn(idBranching), .jumpingIn(idJumping),
    .pcOut(exPc), .aOut(exA), .bOut(exB), .immOut(exImm), .instrOut(),
    .regDstOut(exRegDst), .opOut(exOp), .aluSrcImmOut(exAluSrcImm),
    .regWriteOut(exRegWrite), .memWriteOut(exMemWrite), .memEnOut(exMemEn),
    .dumpOut(exDump), .branchingOut(exBranching), .jumpingOut(exJumping)
  );

  executeStage executeStage_i (
    .clk(clk), .rst(rst), .en(en), .pc(exPc), .a(exA), .b(exB), .imm(exImm),
    .regDst(exRegDst), .op(exOp), .aluSrcImm(exAluSrcImm), .regWrite(exRegWrite),
    .memWriteCtl(exMemWrite), .memEnCtl(exMemEn), .dumpCtl(exDump),
    .branching(exBranching), .jumping(exJumping), .rfWrite(rfWrite), .rfAddr(rfAddr),
    .rfData(rfData), .result(result), .resultReg(resultReg), .resultWrite(resultWrite),
    .memAddr(memAddr), .memData(memData), .memWrite(memWrite), .memEn(memEn),
    .dump(dump), .branchTaken(branchTaken), .branchTarget(branchTarget)
  );

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ns

module executeStage import isaPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   en,
  input  word    pc,
  input  word    a,
  input  word    b,
  input  word    imm,
  input  regAddr regDst,
  input  aluOp   op,
  input  logic   aluSrcImm,
  input  logic   regWrite,
  input  logic   memWriteCtl,
  input  logic   memEnCtl,
  input  logic   dumpCtl,
  input  logic   branching,
  input  logic   jumping,
  output logic   rfWrite,
  output regAddr rfAddr,
  output word    rfData,
  output word    result,
  output regAddr resultReg,
  output logic   resultWrite,
  output word    memAddr,
  output word    memData,
  output logic   memWrite,
  output logic   memEn,
  output logic   dump,
  output logic   branchTaken,
  output word    branchTarget
);

  word  operandB;
  word  aluOut;
  word  storeAddr;
  word  target;
  logic taken;

  assign operandB = aluSrcImm ? imm : b;

  always_comb begin
    case (op)
      OP_SUB:   aluOut = operandB - a;
      OP_XOR:   aluOut = a ^ operandB;
      OP_ANDN:  aluOut = a & ~operandB;
      OP_PASSB: aluOut = operandB;
      OP_SHOR:  aluOut = {a[7:0], 8'h00} | operandB;
      default:  aluOut = a + operandB;
    endcase
  end

  assign storeAddr = a + imm;
  assign target    = pc + 16'd2 + imm;
  assign taken     = jumping | (branching & (a == '0));

  // Writeback happens at the same edge that loads the output register.
  assign rfWrite = regWrite & en;
  assign rfAddr  = regDst;
  assign rfData  = aluOut;

  always_ff @(posedge clk) begin
    if (rst) begin
      result       <= '0;
      resultReg    <= '0;
      resultWrite  <= 1'b0;
      memAddr      <= '0;
      memData      <= '0;
      memWrite     <= 1'b0;
      memEn        <= 1'b0;
      dump         <= 1'b0;
      branchTaken  <= 1'b0;
      branchTarget <= '0;
    end else if (en) begin
      result       <= aluOut;
      resultReg    <= regDst;
      resultWrite  <= regWrite;
      memAddr      <= storeAddr;
      memData      <= b;
      memWrite     <= memWriteCtl;
      memEn        <= memEnCtl;
      dump         <= dumpCtl;
      branchTaken  <= taken;
      branchTarget <= target;
    end
  end

endmodule

//--- hdl/idExLatch.sv
`timescale 1ns/1ns

module idExLatch import isaPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   en,
  input  logic   stall,
  input  word    pcIn,
  input  word    aIn,
  input  word    bIn,
  input  word    immIn,
  input  word    instrIn,
  input  regAddr regDstIn,
  input  aluOp   opIn,
  input  logic   aluSrcImmIn,
  input  logic   regWriteIn,
  input  logic   memWriteIn,
  input  logic   memEnIn,
  input  logic   dumpIn,
  input  logic   branchingIn,
  input  logic   jumpingIn,
  output word    pcOut,
  output word    aOut,
  output word    bOut,
  output word    immOut,
  output word    instrOut,
  output regAddr regDstOut,
  output aluOp   opOut,
  output logic   aluSrcImmOut,
  output logic   regWriteOut,
  output logic   memWriteOut,
  output logic   memEnOut,
  output logic   dumpOut,
  output logic   branchingOut,
  output logic   jumpingOut
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pcOut        <= '0;
      aOut         <= '0;
      bOut         <= '0;
      immOut       <= '0;
      instrOut     <= NOP_WORD;
      regDstOut    <= '0;
      opOut        <= OP_ADD;
      aluSrcImmOut <= 1'b0;
      regWriteOut  <= 1'b0;
      memWriteOut  <= 1'b0;
      memEnOut     <= 1'b0;
      dumpOut      <= 1'b0;
      branchingOut <= 1'b0;
      jumpingOut   <= 1'b0;
    end else if (en) begin
      pcOut        <= pcIn;
      aOut         <= aIn;
      bOut         <= bIn;
      immOut       <= immIn;
      regDstOut    <= regDstIn;
      opOut        <= opIn;
      aluSrcImmOut <= aluSrcImmIn;
      // A stall turns the slot into a bubble, only the side effects are cleared.
      instrOut     <= stall ? NOP_WORD : instrIn;
      regWriteOut  <= regWriteIn & ~stall;
      memWriteOut  <= memWriteIn & ~stall;
      memEnOut     <= memEnIn & ~stall;
      dumpOut      <= dumpIn & ~stall;
      branchingOut <= branchingIn & ~stall;
      jumpingOut   <= jumpingIn & ~stall;
    end
  end

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import isaPkg::*; (
  input  word    instr,
  output regAddr rsAddr,
  output regAddr rtAddr,
  output word    imm,
  output regAddr regDstAddr,
  output aluOp   op,
  output logic   aluSrcImm,
  output logic   regWrite,
  output logic   memWrite,
  output logic   memEn,
  output logic   dump,
  output logic   branching,
  output logic   jumping
);

  opcode  opc;
  aluFunc func;
  seSel   sel;
  regDst  dstSel;

  assign opc    = instr[15:11];
  assign func   = instr[1:0];
  assign rsAddr = instr[10:8];
  assign rtAddr = instr[7:5];

  always_comb begin
    sel       = SE_S5;
    dstSel    = DST_RD;
    op        = OP_ADD;
    aluSrcImm = 1'b0;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    memEn     = 1'b0;
    dump      = 1'b0;
    branching = 1'b0;
    jumping   = 1'b0;
    case (opc)
      OPC_ALU: begin
        regWrite = 1'b1;
        case (func)
          FN_ADD:  op = OP_ADD;
          FN_SUB:  op = OP_SUB;
          FN_XOR:  op = OP_XOR;
          default: op = OP_ANDN;
        endcase
      end
      OPC_ADDI, OPC_SUBI, OPC_XORI, OPC_ANDNI: begin
        dstSel    = DST_RT;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
        case (opc)
          OPC_ADDI: op = OP_ADD;
          OPC_SUBI: op = OP_SUB;
          OPC_XORI: op = OP_XOR;
          default:  op = OP_ANDN;
        endcase
        // The logic immediates are zero-extended, the arithmetic ones sign-extended.
        sel = (opc == OPC_XORI || opc == OPC_ANDNI) ? SE_Z5 : SE_S5;
      end
      OPC_LBI: begin
        sel       = SE_S8;
        dstSel    = DST_RS;
        op        = OP_PASSB;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
      end
      OPC_SLBI: begin
        sel       = SE_Z8;
        dstSel    = DST_RS;
        op        = OP_SHOR;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
      end
      OPC_ST: begin
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
        memEn     = 1'b1;
      end
      OPC_BEQZ: begin
        sel       = SE_S8;
        branching = 1'b1;
      end
      OPC_J: begin
        sel     = SE_S11;
        jumping = 1'b1;
      end
      OPC_HALT: dump = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    case (sel)
      SE_Z5:   imm = {11'b0, instr[4:0]};
      SE_S8:   imm = {{8{instr[7]}}, instr[7:0]};
      SE_Z8:   imm = {8'b0, instr[7:0]};
      SE_S11:  imm = {{5{instr[10]}}, instr[10:0]};
      default: imm = {{11{instr[4]}}, instr[4:0]};
    endcase
  end

  always_comb begin
    case (dstSel)
      DST_RT:  regDstAddr = instr[7:5];
      DST_RS:  regDstAddr = instr[10:8];
      default: regDstAddr = instr[4:2];
    endcase
  end

endmodule

//--- hdl/isaPkg.sv
package isaPkg;

  typedef logic [15:0] word;
  typedef logic [2:0]  regAddr;
  typedef logic [4:0]  opcode;
  typedef logic [1:0]  aluFunc;
  typedef logic [2:0]  seSel;
  typedef logic [1:0]  regDst;

  // Subtract takes the second operand minus A, so SUB gives Rt - Rs and SUBI imm - Rs.
  // And-not keeps A and clears the bits set in the second operand.
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_ANDN,
    OP_PASSB,
    OP_SHOR
  } aluOp;

  localparam int NUM_REGS = 8;

  localparam opcode OPC_HALT  = 5'b00000;
  localparam opcode OPC_NOP   = 5'b00001;
  localparam opcode OPC_J     = 5'b00100;
  localparam opcode OPC_ADDI  = 5'b01000;
  localparam opcode OPC_SUBI  = 5'b01001;
  localparam opcode OPC_XORI  = 5'b01010;
  localparam opcode OPC_ANDNI = 5'b01011;
  localparam opcode OPC_BEQZ  = 5'b01100;
  localparam opcode OPC_ST    = 5'b10000;
  localparam opcode OPC_SLBI  = 5'b10010;
  localparam opcode OPC_LBI   = 5'b11000;
  localparam opcode OPC_ALU   = 5'b11011;

  localparam aluFunc FN_ADD  = 2'b00;
  localparam aluFunc FN_SUB  = 2'b01;
  localparam aluFunc FN_XOR  = 2'b10;
  localparam aluFunc FN_ANDN = 2'b11;

  localparam seSel SE_S5  = 3'd0;
  localparam seSel SE_Z5  = 3'd1;
  localparam seSel SE_S8  = 3'd2;
  localparam seSel SE_Z8  = 3'd3;
  localparam seSel SE_S11 = 3'd4;

  localparam regDst DST_RD = 2'd0;
  localparam regDst DST_RT = 2'd1;
  localparam regDst DST_RS = 2'd2;

  localparam word NOP_WORD = {OPC_NOP, 11'b0};

endpackage

//--- hdl/registerFile.sv
`timescale 1ns/1ns

module registerFile import isaPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  regAddr rsAddr,
  input  regAddr rtAddr,
  input  regAddr writeAddr,
  input  word    writeData,
  input  logic   write,
  output word    rsData,
  output word    rtData
);

  word regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[writeAddr] <= writeData;
    end
  end

  // A write landing this cycle is forwarded so the next decode sees it.
  assign rsData = (write && writeAddr == rsAddr) ? writeData : regs[rsAddr];
  assign rtData = (write && writeAddr == rtAddr) ? writeData : regs[rtAddr];

endmodule

//--- tb/decodeExecuteTb.sv
`timescale 1ns/1ns

module decodeExecuteTb import isaPkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;

  typedef struct packed {
    logic   wr;
    regAddr dst;
    word    value;
    logic   mem;
    word    addr;
    word    data;
    logic   halt;
    logic   taken;
    word    target;
  } expectSlot;

  logic   clk;
  logic   rst;
  word    instr;
  word    pc;
  logic   en;
  logic   stall;
  word    result;
  regAddr resultReg;
  logic   resultWrite;
  word    memAddr;
  word    memData;
  logic   memWrite;
  logic   memEn;
  logic   dump;
  logic   branchTaken;
  word    branchTarget;

  word         model [NUM_REGS];
  expectSlot   inLatch;
  expectSlot   shown;
  word         pcNext;
  int          seed = 73;
  logic [31:0] rnd;
  int          passCount = 0;
  int          failCount = 0;
  int          testStartFails = 0;
  int          cycleCount = 0;
  opcode       iOps [4] = '{OPC_ADDI, OPC_SUBI, OPC_XORI, OPC_ANDNI};

  decodeExecute decodeExecute_i (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleCount);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic word rFormat(regAddr rs, regAddr rt, regAddr rd, aluFunc fn);
    return {OPC_ALU, rs, rt, rd, fn};
  endfunction

  function automatic word iFormat(opcode opc, regAddr rs, regAddr rt, logic [4:0] imm5);
    return {opc, rs, rt, imm5};
  endfunction

  function automatic word byteFormat(opcode opc, regAddr rs, logic [7:0] imm8);
    return {opc, rs, imm8};
  endfunction

  // Reference model of one instruction, read against the register state it will see.
  function automatic expectSlot predict(word ins, word pcv, logic stalled);
    expectSlot e;
    word a;
    word b;
    word s5;
    word z5;
    word s8;
    word z8;
    e = '0;
    a = model[ins[10:8]];
    b = model[ins[7:5]];
    s5 = {{11{ins[4]}}, ins[4:0]};
    z5 = {11'b0, ins[4:0]};
    s8 = {{8{ins[7]}}, ins[7:0]};
    z8 = {8'b0, ins[7:0]};
    case (ins[15:11])
      OPC_ALU: begin
        e.wr = 1'b1;
        e.dst = ins[4:2];
        case (ins[1:0])
          FN_ADD:  e.value = a + b;
          FN_SUB:  e.value = b - a;
          FN_XOR:  e.value = a ^ b;
          default: e.value = a & ~b;
        endcase
      end
      OPC_ADDI, OPC_SUBI, OPC_XORI, OPC_ANDNI: begin
        e.wr = 1'b1;
        e.dst = ins[7:5];
        if (ins[15:11] == OPC_ADDI) e.value = a + s5;
        else if (ins[15:11] == OPC_SUBI) e.value = s5 - a;
        else if (ins[15:11] == OPC_XORI) e.value = a ^ z5;
        else e.value = a & ~z5;
      end
      OPC_LBI, OPC_SLBI: begin
        e.wr = 1'b1;
        e.dst = ins[10:8];
        e.value = (ins[15:11] == OPC_LBI) ? s8 : ((a << 8) | z8);
      end
      OPC_ST: begin
        e.mem = 1'b1;
        e.addr = a + s5;
        e.data = b;
      end
      OPC_BEQZ: begin
        e.taken = (a == 16'h0000);
        e.target = pcv + 16'd2 + s8;
      end
      OPC_J: begin
        e.taken = 1'b1;
        e.target = pcv + 16'd2 + {{5{ins[10]}}, ins[10:0]};
      end
      OPC_HALT: e.halt = 1'b1;
      default: ;
    endcase
    if (stalled) e = '0;
    return e;
  endfunction

  task automatic checkValue(input string name, input word got, input word exp);
    assert (got === exp) begin
      passCount++;
    end else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      failCount++;
    end
  endtask

  task automatic compareOutputs();
    checkValue("resultWrite", word'(resultWrite), word'(shown.wr));
    checkValue("memWrite", word'(memWrite), word'(shown.mem));
    checkValue("memEn", word'(memEn), word'(shown.mem));
    checkValue("dump", word'(dump), word'(shown.halt));
    checkValue("branchTaken", word'(branchTaken), word'(shown.taken));
    if (shown.wr) begin
      checkValue("result", result, shown.value);
      checkValue("resultReg", word'(resultReg), word'(shown.dst));
    end
    if (shown.mem) begin
      checkValue("memAddr", memAddr, shown.addr);
      checkValue("memData", memData, shown.data);
    end
    if (shown.taken) checkValue("branchTarget", branchTarget, shown.target);
  endtask

  // The slot in execute writes back at the coming edge, so the model commits it first.
  task automatic issue(input word ins, input logic stallIn);
    @(negedge clk);
    compareOutputs();
    instr = ins;
    pc = pcNext;
    en = 1'b1;
    stall = stallIn;
    if (inLatch.wr) model[inLatch.dst] = inLatch.value;
    shown = inLatch;
    inLatch = predict(ins, pcNext, stallIn);
    pcNext = pcNext + 16'd2;
  endtask

  task automatic holdCycles(input word ins, input int n);
    repeat (n) begin
      @(negedge clk);
      compareOutputs();
      instr = ins;
      pc = pcNext;
      en = 1'b0;
      stall = 1'b0;
    end
  endtask

  task automatic endTest(input string name);
    issue(NOP_WORD, 1'b0);
    issue(NOP_WORD, 1'b0);
    $display("%s finished with %0d errors", name, failCount - testStartFails);
    testStartFails = failCount;
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instr = NOP_WORD;
    pc = '0;
    en = 1'b0;
    stall = 1'b0;
    pcNext = 16'h0100;
    inLatch = '0;
    shown = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    issue(rFormat(3'd0, 3'd0, 3'd1, FN_ADD), 1'b0);
    endTest("reset");

    issue(byteFormat(OPC_LBI, 3'd3, 8'hFB), 1'b0);
    issue(byteFormat(OPC_LBI, 3'd4, 8'h7F), 1'b0);
    issue(byteFormat(OPC_SLBI, 3'd3, 8'h12), 1'b0);
    issue(byteFormat(OPC_LBI, 3'd5, 8'h80), 1'b0);
    issue(byteFormat(OPC_SLBI, 3'd5, 8'hF0), 1'b0);
    endTest("constants");

    for (int i = 0; i < 150; i++) begin
      rnd = $random(seed);
      if (rnd[3]) issue(rFormat(rnd[6:4], rnd[9:7], rnd[12:10], rnd[1:0]), 1'b0);
      else issue(iFormat(iOps[rnd[1:0]], rnd[6:4], rnd[9:7], rnd[14:10]), 1'b0);
    end
    endTest("alu");

    issue(byteFormat(OPC_LBI, 3'd6, 8'h11), 1'b0);
    issue(byteFormat(OPC_LBI, 3'd6, 8'h2A), 1'b1);
    issue(iFormat(OPC_ST, 3'd6, 3'd6, 5'h01), 1'b1);
    issue({OPC_HALT, 11'b0}, 1'b1);
    issue(rFormat(3'd6, 3'd0, 3'd7, FN_ADD), 1'b0);
    endTest("stall");

    issue(iFormat(OPC_ADDI, 3'd2, 3'd2, 5'd1), 1'b0);
    rnd = $random(seed);
    holdCycles(iFormat(OPC_ADDI, 3'd2, 3'd3, 5'd0), 1 + int'(rnd % 5));
    issue(iFormat(OPC_ADDI, 3'd2, 3'd3, 5'd0), 1'b0);
    endTest("enable hold");

    issue(byteFormat(OPC_LBI, 3'd1, 8'h00), 1'b0);
    issue(byteFormat(OPC_BEQZ, 3'd1, 8'h06), 1'b0);
    issue(byteFormat(OPC_LBI, 3'd2, 8'h03), 1'b0);
    issue(byteFormat(OPC_BEQZ, 3'd2, 8'hFC), 1'b0);
    issue({OPC_J, 11'd100}, 1'b0);
    issue({OPC_J, 11'h7CE}, 1'b0);
    issue(byteFormat(OPC_LBI, 3'd3, 8'h40), 1'b0);
    issue(byteFormat(OPC_LBI, 3'd4, 8'h5A), 1'b0);
    issue(iFormat(OPC_ST, 3'd3, 3'd4, 5'h1E), 1'b0);
    issue({OPC_HALT, 11'b0}, 1'b0);
    endTest("control and memory");

    $display("checks passed %0d, failed %0d, assertion violations %0d",
             passCount, failCount, decodeExecute_i.svaChecks.violations);
    if (failCount == 0 && decodeExecute_i.svaChecks.violations == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb/decodeExecute_sva.sv
`timescale 1ns/1ns

module decodeExecute_sva (
  input logic clk,
  input logic rst,
  input logic en,
  input logic stall,
  input logic resultWrite,
  input logic memWrite,
  input logic memEn,
  input logic dump,
  input logic branchTaken,
  input logic exBranching,
  input logic exJumping
);

  int   violations = 0;
  logic anyControl;

  assign anyControl = resultWrite | memWrite | memEn | dump | branchTaken;

  noWriteConflict: assert property (@(posedge clk) disable iff (rst)
    !(memWrite && resultWrite))
    else begin
      $error("memWrite and resultWrite high together");
      violations++;
    end

  quietAfterReset: assert property (@(posedge clk) rst |=> !anyControl)
    else begin
      $error("control output high after a reset cycle");
      violations++;
    end

  // The bubble reaches the outputs at the next enabled edge after its capture.
  bubbleIsQuiet: assert property (@(posedge clk) disable iff (rst)
    (en && stall) ##1 en |=> !anyControl)
    else begin
      $error("stalled slot produced a control output");
      violations++;
    end

  takenNeedsTransfer: assert property (@(posedge clk) disable iff (rst)
    $rose(branchTaken) |-> $past(exBranching || exJumping))
    else begin
      $error("branchTaken rose without a branch or jump in the slot");
      violations++;
    end

endmodule

bind decodeExecute decodeExecute_sva svaChecks (
  .clk(clk),
  .rst(rst),
  .en(en),
  .stall(stall),
  .resultWrite(resultWrite),
  .memWrite(memWrite),
  .memEn(memEn),
  .dump(dump),
  .branchTaken(branchTaken),
  .exBranching(exBranching),
  .exJumping(exJumping)
);
